//--- Makefile
TOP := spi_flash_emu_tb

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f spi_flash_emu.f -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module spi_flash_emu -f spi_flash_emu.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- common/flash_pkg.sv
// shared flash definitions; RAM index wraps above byte address bit 10, SFDP region picked by bits 31:24
package flash_pkg;

	// JEDEC command codes that the device understands
	localparam logic [7:0] cmd_read = 8'h03;
	localparam logic [7:0] cmd_sfdp = 8'h5a;
	localparam logic [7:0] cmd_rdsr = 8'h05;
	localparam logic [7:0] cmd_wren = 8'h06;
	localparam logic [7:0] cmd_wrds = 8'h04;
	localparam logic [7:0] cmd_rdid = 8'h9f;

	// manufacturer, type and capacity bytes of a 16 MB part
	localparam logic [23:0] jedec_id = 24'hc22018;
	// SFDP table sits above the normal 16 MB space
	localparam logic [7:0] sfdp_offset = 8'h01;
	// tag in the upper log address for an unknown command
	localparam logic [15:0] log_unknown_tag = 16'hc0de;

	localparam int ram_index_bits = 11;
	localparam int ram_words = 2 ** ram_index_bits;
	// clk cycles from read_enable to valid
	localparam int ram_latency = 3;

	typedef struct packed {
		logic [7:0] data;
		logic [2:0] bit_idx;
		logic bit_strobe;
		logic byte_strobe;
		logic first;
		logic cs_active;
	} rx_event_t;

	typedef struct packed {
		logic [31:0] addr;
		logic read_enable;
	} ram_req_t;

	typedef struct packed {
		logic [15:0] data;
		logic valid;
	} ram_rsp_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [7:0] len;
	} log_rec_t;

	typedef struct packed {
		logic enable;
		logic [ram_index_bits-1:0] index;
		logic [15:0] data;
	} preload_t;

	// region bit on top, word bits from byte address 10:1
	function automatic logic [ram_index_bits-1:0] ram_index(input logic [31:0] byte_addr);
		return {byte_addr[31:24] == sfdp_offset, byte_addr[10:1]};
	endfunction

endpackage

//--- rtl/flash_cmd_ctrl.sv
// serial flash command decoder; no program or erase, data must return within one sclk bit time
`timescale 1ns/1ps

module flash_cmd_ctrl import flash_pkg::*; (
	input logic clk,
	input logic reset,
	input rx_event_t rx,
	output ram_req_t ram_req,
	input ram_rsp_t ram_rsp,
	output logic [7:0] tx_byte,
	output logic tx_strobe,
	output log_rec_t log,
	output logic log_strobe,
	output logic [7:0] errors
);
	typedef enum logic [1:0] {
		mode_idle,
		mode_read,
		mode_rdid
	} mode_t;

	mode_t mode;
	// number of the byte now arriving, command is byte 0
	logic [2:0] byte_cnt;
	logic is_sfdp;
	logic wel;
	logic [31:0] addr;
	logic [15:0] rd_data;
	logic rd_ready;
	logic late_pending;
	logic late_sel;
	logic cs_prev;
	logic [2:0] load_start;
	logic [31:0] cur_addr;
	logic [31:0] fetch_addr;
	logic rsp_take;
	logic word_ok;
	logic [15:0] word;
	logic [7:0] status;

	// only the write enable latch is live
	assign status = {6'b0, wel, 1'b0};
	// byte whose strobe loads the first data byte, one later for the SFDP dummy
	assign load_start = is_sfdp ? 3'd4 : 3'd3;
	// while the last address byte arrives, its bits come straight from rx
	assign cur_addr = (byte_cnt == 3'd3) ? {addr[31:8], rx.data} : addr;
	// seven bits in, the word address is complete
	assign fetch_addr = (byte_cnt == 3'd3) ? {addr[31:8], rx.data[6:0], 1'b0} : addr;
	assign rsp_take = ram_req.read_enable && ram_rsp.valid;
	// data returning in the same cycle counts as ready
	assign word_ok = (rd_ready || rsp_take) && !late_pending;
	assign word = rd_ready ? rd_data : ram_rsp.data;

	always_ff @(posedge clk) begin
		tx_strobe <= 1'b0;
		log_strobe <= 1'b0;
		cs_prev <= rx.cs_active;
		if (reset) begin
			mode <= mode_idle;
			byte_cnt <= 3'd0;
			is_sfdp <= 1'b0;
			wel <= 1'b0;
			rd_ready <= 1'b0;
			late_pending <= 1'b0;
			ram_req.read_enable <= 1'b0;
			errors <= 8'h00;
			cs_prev <= 1'b0;
		end else if (!rx.cs_active) begin
			// deselect ends the transaction, log a read once its address is known
			if (cs_prev && mode == mode_read && byte_cnt >= 3'd4)
				log_strobe <= 1'b1;
			mode <= mode_idle;
			byte_cnt <= 3'd0;
			rd_ready <= 1'b0;
			late_pending <= 1'b0;
			ram_req.read_enable <= 1'b0;
		end else begin
			// fetch returned, drop the request and keep the word
			if (rsp_take) begin
				ram_req.read_enable <= 1'b0;
				rd_data <= ram_rsp.data;
				rd_ready <= 1'b1;
				// a byte boundary already passed, send it right away
				if (late_pending) begin
					tx_byte <= late_sel ? ram_rsp.data[15:8] : ram_rsp.data[7:0];
					tx_strobe <= 1'b1;
					late_pending <= 1'b0;
					rd_ready <= 1'b0;
				end
			end

			if (rx.first) begin
				byte_cnt <= 3'd1;
				mode <= mode_idle;
				is_sfdp <= 1'b0;
				addr <= 32'h0;
				log.len <= 8'h00;
				case (rx.data)
					cmd_read: begin
						mode <= mode_read;
					end
					cmd_sfdp: begin
						mode <= mode_read;
						is_sfdp <= 1'b1;
						addr[31:24] <= sfdp_offset;
					end
					cmd_rdsr: begin
						tx_byte <= status;
						tx_strobe <= 1'b1;
					end
					cmd_wren: begin
						wel <= 1'b1;
					end
					cmd_wrds: begin
						wel <= 1'b0;
					end
					cmd_rdid: begin
						mode <= mode_rdid;
						tx_byte <= jedec_id[23:16];
						tx_strobe <= 1'b1;
					end
					default: begin
						// program, erase and anything else end up here
						log.addr <= {log_unknown_tag, 8'h00, rx.data};
						log.len <= rx.data;
						log_strobe <= 1'b1;
						errors[7] <= 1'b1;
					end
				endcase
			end else if (rx.byte_strobe) begin
				if (byte_cnt != 3'd7)
					byte_cnt <= byte_cnt + 3'd1;

				// remaining identity bytes, one per byte time
				if (mode == mode_rdid && byte_cnt == 3'd1) begin
					tx_byte <= jedec_id[15:8];
					tx_strobe <= 1'b1;
				end else if (mode == mode_rdid && byte_cnt == 3'd2) begin
					tx_byte <= jedec_id[7:0];
					tx_strobe <= 1'b1;
				end

				if (mode == mode_read) begin
					case (byte_cnt)
						3'd1: addr[23:16] <= rx.data;
						3'd2: addr[15:8] <= rx.data;
						3'd3: begin
							addr[7:0] <= rx.data;
							// start address keeps its region bits
							log.addr <= {addr[31:8], rx.data};
						end
						default: ;
					endcase

					if (byte_cnt >= load_start) begin
						// low 24 bits wrap, region bits stay put
						addr[23:0] <= cur_addr[23:0] + 24'd1;
						log.len <= log.len + 8'd1;
						if (word_ok) begin
							tx_byte <= cur_addr[0] ? word[15:8] : word[7:0];
							tx_strobe <= 1'b1;
							rd_ready <= 1'b0;
						end else begin
							late_pending <= 1'b1;
							late_sel <= cur_addr[0];
							if (byte_cnt == load_start)
								errors[6] <= 1'b1;
							else
								errors[5] <= 1'b1;
						end
					end
				end
			end else if (rx.bit_strobe && rx.bit_idx == 3'd1 && mode == mode_read
				&& byte_cnt >= load_start) begin
				// one bit before the boundary, fetch the word for the next byte
				if (ram_req.read_enable && !rsp_take)
					errors[4] <= 1'b1;
				ram_req.read_enable <= 1'b1;
				ram_req.addr <= fetch_addr;
				rd_ready <= 1'b0;
			end
		end
	end

	// a load only makes sense inside a transaction the receiver still sees
	assert property (@(posedge clk) disable iff (reset) tx_strobe |-> rx.cs_active);

endmodule

//--- rtl/spi_flash_emu.sv
// serial flash emulator top; single I/O mode 0 only, preload the RAM before any SPI traffic
`timescale 1ns/1ps

module spi_flash_emu import flash_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sclk,
	input logic cs_n,
	input logic mosi,
	output logic miso,
	input preload_t preload,
	output log_rec_t log,
	output logic log_strobe,
	output logic [7:0] errors
);
	rx_event_t rx;
	ram_req_t ram_req;
	ram_rsp_t ram_rsp;
	logic [7:0] tx_byte;
	logic tx_strobe;

	// bit and byte events from the SPI pins
	spi_slave_rx spi_slave_rx_inst (
		.clk(clk),
		.reset(reset),
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.rx(rx)
	);

	// miso shifter, keeps its own pin synchronizers
	spi_slave_tx spi_slave_tx_inst (
		.clk(clk),
		.reset(reset),
		.sclk(sclk),
		.cs_n(cs_n),
		.tx_byte(tx_byte),
		.tx_strobe(tx_strobe),
		.miso(miso)
	);

	flash_cmd_ctrl flash_cmd_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.ram_req(ram_req),
		.ram_rsp(ram_rsp),
		.tx_byte(tx_byte),
		.tx_strobe(tx_strobe),
		.log(log),
		.log_strobe(log_strobe),
		.errors(errors)
	);

	word_ram word_ram_inst (
		.clk(clk),
		.reset(reset),
		.req(ram_req),
		.rsp(ram_rsp),
		.preload(preload)
	);

endmodule

//--- rtl/spi_slave/spi_slave_rx.sv
// SPI mode 0 receiver, MSB first; sclk half-period must be at least 4 clk, events lag pins by 2 clk
`timescale 1ns/1ps

module spi_slave_rx import flash_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sclk,
	input logic cs_n,
	input logic mosi,
	output rx_event_t rx
);
	logic [1:0] sclk_sync;
	logic [1:0] cs_n_sync;
	logic [1:0] mosi_sync;
	logic sclk_prev;
	logic sclk_rise;
	logic [6:0] shift;
	logic [2:0] bit_cnt;
	logic first_pending;

	// two-stage synchronizers on all three pins
	always_ff @(posedge clk) begin
		if (reset) begin
			sclk_sync <= 2'b00;
			cs_n_sync <= 2'b11;
			sclk_prev <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			cs_n_sync <= {cs_n_sync[0], cs_n};
			sclk_prev <= sclk_sync[1];
		end
	end

	// mosi travels with the same delay as sclk, so it is stable at the rise
	always_ff @(posedge clk)
		mosi_sync <= {mosi_sync[0], mosi};

	assign sclk_rise = sclk_sync[1] && !sclk_prev;

	// bit counter restarts at 7 whenever the chip is deselected
	always_ff @(posedge clk) begin
		if (reset || cs_n_sync[1]) begin
			bit_cnt <= 3'd7;
			first_pending <= 1'b1;
		end else if (sclk_rise) begin
			bit_cnt <= bit_cnt - 3'd1;
			// command byte done
			if (bit_cnt == 3'd0)
				first_pending <= 1'b0;
		end
	end

	// only seven bits are kept, the newest bit comes straight from the sync stage
	always_ff @(posedge clk)
		if (sclk_rise)
			shift <= {shift[5:0], mosi_sync[1]};

	always_comb begin
		rx.data = {shift, mosi_sync[1]};
		rx.bit_idx = bit_cnt;
		rx.bit_strobe = sclk_rise;
		rx.byte_strobe = sclk_rise && bit_cnt == 3'd0;
		rx.first = rx.byte_strobe && first_pending;
		rx.cs_active = !cs_n_sync[1];
	end

	// host must not clock sclk while deselected
	assert property (@(posedge clk) disable iff (reset)
		(rx.bit_strobe || rx.byte_strobe) |-> !cs_n_sync[1]);

endmodule

//--- rtl/spi_slave/spi_slave_tx.sv
// SPI mode 0 transmitter; a byte loaded during byte N goes out during byte N+1, else ones
`timescale 1ns/1ps

module spi_slave_tx (
	input logic clk,
	input logic reset,
	input logic sclk,
	input logic cs_n,
	input logic [7:0] tx_byte,
	input logic tx_strobe,
	output logic miso
);
	logic [1:0] sclk_sync;
	logic [1:0] cs_n_sync;
	logic sclk_prev;
	logic sclk_fall;
	logic [2:0] fall_cnt;
	logic [7:0] pending;
	logic pending_valid;
	logic [7:0] shift;

	always_ff @(posedge clk) begin
		if (reset) begin
			sclk_sync <= 2'b00;
			cs_n_sync <= 2'b11;
			sclk_prev <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			cs_n_sync <= {cs_n_sync[0], cs_n};
			sclk_prev <= sclk_sync[1];
		end
	end

	assign sclk_fall = !sclk_sync[1] && sclk_prev;

	always_ff @(posedge clk) begin
		if (reset || cs_n_sync[1]) begin
			fall_cnt <= 3'd0;
			shift <= 8'hff;
			pending_valid <= 1'b0;
		end else begin
			if (sclk_fall) begin
				fall_cnt <= fall_cnt + 3'd1;
				// eighth falling edge ends the byte, next MSB goes out now
				if (fall_cnt == 3'd7) begin
					shift <= pending_valid ? pending : 8'hff;
					pending_valid <= 1'b0;
				end else begin
					shift <= {shift[6:0], 1'b1};
				end
			end
			// a load wins over the boundary that empties the slot
			if (tx_strobe)
				pending_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
		if (tx_strobe)
			pending <= tx_byte;

	assign miso = shift[7];

endmodule

//--- rtl/word_ram.sv
// 2048 x 16 flash image; preload only while no read is running, contents undefined until loaded
`timescale 1ns/1ps

module word_ram import flash_pkg::*; (
	input logic clk,
	input logic reset,
	input ram_req_t req,
	output ram_rsp_t rsp,
	input preload_t preload
);
	logic [15:0] mem [ram_words];
	logic [15:0] data_pipe [ram_latency];
	logic [ram_latency-1:0] valid_pipe;

	// host port writes whole words by index
	always_ff @(posedge clk)
		if (preload.enable)
			mem[preload.index] <= preload.data;

	// read data walks down the pipe, stage 0 is the array read
	always_ff @(posedge clk) begin
		if (req.read_enable)
			data_pipe[0] <= mem[ram_index(req.addr)];
		for (int i = 1; i < ram_latency; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	// valid follows read_enable up and down with the same delay
	always_ff @(posedge clk) begin
		if (reset)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[ram_latency-2:0], req.read_enable};
	end

	assign rsp.data = data_pipe[ram_latency-1];
	assign rsp.valid = valid_pipe[ram_latency-1];

	// the host load and SPI reads share the array
	assert property (@(posedge clk) disable iff (reset)
		!(preload.enable && req.read_enable));

endmodule

//--- spi_flash_emu.f
common/flash_pkg.sv
rtl/spi_slave/spi_slave_rx.sv
rtl/spi_slave/spi_slave_tx.sv
rtl/word_ram.sv
rtl/flash_cmd_ctrl.sv
rtl/spi_flash_emu.sv
tests/spi_flash_emu_tb.sv

//--- tests/spi_flash_emu_tb.sv
// flash emulator testbench; SPI host runs at 5 clk per sclk half-period, RAM preloaded with random words
`timescale 1ns/1ps

module spi_flash_emu_tb import flash_pkg::*; ();
	localparam int half_period = 5;
	localparam int byte_cycles = 16 * half_period;
	// preload plus at most 520 SPI byte times, gaps between transactions included
	localparam int test_cycles = ram_words + 520 * byte_cycles;
	localparam int timeout_cycles = 2 * test_cycles;

	logic clk = 1'b0;
	logic reset;
	logic sclk;
	logic cs_n;
	logic mosi;
	logic miso;
	preload_t preload;
	log_rec_t log;
	logic log_strobe;
	logic [7:0] errors;

	// testbench copy of the flash image
	logic [15:0] image [ram_words];
	log_rec_t expected_logs [$];
	int cycle_count = 0;

	spi_flash_emu spi_flash_emu_inst (
		.clk(clk),
		.reset(reset),
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.preload(preload),
		.log(log),
		.log_strobe(log_strobe),
		.errors(errors)
	);

	always #20 clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_log(input log_rec_t got, input log_rec_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail log: got addr %h len %h, expected addr %h len %h",
				got.addr, got.len, exp.addr, exp.len));
	endtask

	task automatic check_errors(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail errors: got %h, expected %h", got, exp));
	endtask

	// bit 10 of the index picks the SFDP region and byte bit 0 picks the half
	function automatic logic [7:0] expected_byte(input logic [31:0] byte_addr);
		logic [10:0] idx;
		logic [15:0] word;
		idx = {byte_addr[31:24] == sfdp_offset, byte_addr[10:1]};
		word = image[idx];
		return byte_addr[0] ? word[15:8] : word[7:0];
	endfunction

	// inputs change a little after the rising edge
	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#5;
	endtask

	// sends one mode 0 byte MSB first and takes miso at the rising sclk
	task automatic spi_byte(input logic [7:0] out_byte, output logic [7:0] in_byte);
		for (int i = 7; i >= 0; i--) begin
			mosi = out_byte[i];
			tick(half_period);
			sclk = 1'b1;
			in_byte[i] = miso;
			tick(half_period);
			sclk = 1'b0;
		end
	endtask

	task automatic spi_deselect();
		tick(half_period);
		cs_n = 1'b1;
		// room for the log strobe and the receiver to see the idle bus
		tick(8);
	endtask

	task automatic preload_ram();
		for (int i = 0; i < ram_words; i++) begin
			image[i] = 16'($urandom);
			preload.enable = 1'b1;
			preload.index = 11'(i);
			preload.data = image[i];
			tick(1);
		end
		preload = '0;
		tick(1);
	endtask

	task automatic single_command(input logic [7:0] cmd);
		logic [7:0] unused;
		cs_n = 1'b0;
		spi_byte(cmd, unused);
		spi_deselect();
	endtask

	task automatic status_check(input logic [7:0] exp);
		logic [7:0] got;
		cs_n = 1'b0;
		spi_byte(cmd_rdsr, got);
		spi_byte(8'h00, got);
		check_byte("miso status", got, exp);
		spi_deselect();
	endtask

	task automatic id_check();
		logic [7:0] got;
		cs_n = 1'b0;
		spi_byte(cmd_rdid, got);
		spi_byte(8'h00, got);
		check_byte("miso id byte 0", got, 8'hc2);
		spi_byte(8'h00, got);
		check_byte("miso id byte 1", got, 8'h20);
		spi_byte(8'h00, got);
		check_byte("miso id byte 2", got, 8'h18);
		spi_deselect();
	endtask

	// SFDP takes one dummy byte after the address
	task automatic read_check(input logic sfdp, input logic [23:0] start, input int count);
		logic [31:0] addr;
		logic [7:0] got;
		log_rec_t rec;
		addr = {sfdp ? sfdp_offset : 8'h00, start};
		rec.addr = addr;
		// the last header byte already loads a data byte, so loads run one past the count
		rec.len = 8'(count + 1);
		expected_logs.push_back(rec);
		cs_n = 1'b0;
		spi_byte(sfdp ? cmd_sfdp : cmd_read, got);
		spi_byte(start[23:16], got);
		spi_byte(start[15:8], got);
		spi_byte(start[7:0], got);
		if (sfdp)
			spi_byte(8'h00, got);
		for (int k = 0; k < count; k++) begin
			spi_byte(8'h00, got);
			check_byte($sformatf("miso @%h", addr), got, expected_byte(addr));
			// only the low 24 bits count up
			addr = {addr[31:24], addr[23:0] + 24'd1};
		end
		spi_deselect();
	endtask

	task automatic unknown_check(input logic [7:0] cmd);
		log_rec_t rec;
		rec.addr = {16'hc0de, 8'h00, cmd};
		rec.len = cmd;
		expected_logs.push_back(rec);
		single_command(cmd);
	endtask

	// log records compared in the middle of the clock period
	always @(negedge clk) begin
		if (!reset && log_strobe) begin
			if (expected_logs.size() == 0)
				stop_with_failure("a log record came out when none was expected");
			else
				check_log(log, expected_logs.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			stop_with_failure($sformatf("run did not finish within %0d cycles", timeout_cycles));
	end

	initial begin
		void'($urandom(32'h0949_d755));
		reset = 1'b1;
		sclk = 1'b0;
		cs_n = 1'b1;
		mosi = 1'b0;
		preload = '0;
		tick(5);
		reset = 1'b0;
		tick(2);
		check_errors(errors, 8'h00);
		preload_ram();

		id_check();
		status_check(8'h00);
		single_command(cmd_wren);
		status_check(8'h02);
		single_command(cmd_wrds);
		status_check(8'h00);

		for (int n = 0; n < 20; n++)
			read_check(1'b0, 24'($urandom), int'($urandom_range(16, 1)));
		for (int n = 0; n < 4; n++)
			read_check(1'b1, 24'($urandom), int'($urandom_range(8, 1)));
		// no late data and no overlapping fetch on legal traffic
		check_errors(errors, 8'h00);

		// page program and sector erase are not supported
		unknown_check(8'h02);
		unknown_check(8'hd8);
		check_errors(errors, 8'h80);

		tick(10);
		if (expected_logs.size() != 0) begin
			stop_with_failure($sformatf("%0d expected log records never came out",
				expected_logs.size()));
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule
